/* design/xc_config.svh */
/*
  Build-time settings for the cross-correlator control block.
  XC_NUM_LINES is legal from 1 to 8; the register map must fit in
  the word address space, so 2 + 2*XC_NUM_LINES words are needed.
  Changing a value here changes every package and module that uses it.
*/
`ifndef XC_CONFIG_SVH
`define XC_CONFIG_SVH

// Number of correlator lines.
`define XC_NUM_LINES 4

// Wishbone word address and data widths.
`define XC_WB_ADDR_W 5
`define XC_WB_DATA_W 32

// Register map. Command and global word, then two words per line.
`define XC_REG_CMD       0
`define XC_REG_LINE_BASE 2

`endif

/* design/xc_cmd_pkg.sv */
/*
  Host command types and the host bus word types.
  A command is one byte, opcode in the low nibble, argument in the
  high nibble. Opcodes 4 to 7 all mean SET_DELAY, with bits 1:0
  selecting the tap, so only 4 carries a name in the enum.
*/
`include "xc_config.svh"

package xc_cmd_pkg;

	// Host bus word types.
	typedef logic [`XC_WB_ADDR_W-1:0] wb_adr_t;
	typedef logic [`XC_WB_DATA_W-1:0] wb_data_t;

	// One host command byte.
	typedef logic [7:0] cmd_byte_t;

	// Opcode in the low nibble of a command.
	typedef enum logic [3:0] {
		op_clear          = 4'd0,
		op_set_line       = 4'd1,
		op_set_leds       = 4'd2,
		op_set_baud       = 4'd3,
		op_set_delay      = 4'd4,
		op_set_freq_div   = 4'd8,
		op_set_voltage    = 4'd9,
		op_enable_test    = 4'd12,
		op_enable_capture = 4'd13
	} opcode_e;

	// Command from the bus stage to the parser.
	typedef struct packed {
		logic      valid;
		cmd_byte_t data;
	} cmd_t;

	// Opcode field of a command byte.
	function automatic opcode_e cmd_opcode(cmd_byte_t c);
		return opcode_e'(c[3:0]);
	endfunction

	// The whole group 4 to 7 sets a delay tap.
	function automatic logic cmd_is_delay(cmd_byte_t c);
		return c[3:2] == op_set_delay[3:2];
	endfunction

endpackage

/* design/xc_cfg_pkg.sv */
/*
  Configuration types of the correlator control block.
  line_cfg_t is 40 bits and global_cfg_t is 19 bits; the first field
  of each struct sits in the high bits. The readback words and the
  exported ports both use these layouts, so keep the field order.
*/
`include "xc_config.svh"

package xc_cfg_pkg;

	// One 3-bit delay tap.
	typedef logic [2:0] tap_t;

	// Four delay taps, tap 0 in the low bits.
	typedef logic [11:0] delay_idx_t;

	// Bias voltage code, also the PWM phase scale.
	typedef logic [7:0] bias_t;

	// Test pattern, LED pattern, baud rate and clock divider.
	typedef logic [3:0] nibble_t;

	// Currently selected line.
	typedef logic [7:0] line_sel_t;

	// Settings of one correlator line.
	typedef struct packed {
		delay_idx_t cross_idx;
		delay_idx_t auto_idx;
		bias_t      bias;
		nibble_t    test;
		nibble_t    leds;
	} line_cfg_t;

	// Settings shared by all lines.
	typedef struct packed {
		line_sel_t current_line;
		nibble_t   baud_rate;
		nibble_t   clock_divider;
		logic      integrating;
		logic      external_clock;
		logic      fullwave;
	} global_cfg_t;

	// One entry per line, line 0 in the low bits.
	typedef line_cfg_t [`XC_NUM_LINES-1:0] line_cfg_arr_t;
	typedef bias_t [`XC_NUM_LINES-1:0] bias_arr_t;

endpackage

/* design/cmd_wb_slave.sv */
/*
  Wishbone classic slave for the control registers.
  Every transfer is acked one cycle after the request, with no wait
  states and no error response. sel is not supported, so only full
  words are meaningful; a write to the command word uses bits 7:0.
  Read data is valid in the ack cycle only.
*/
`timescale 1ns/1ps
`include "xc_config.svh"

module cmd_wb_slave
	import xc_cmd_pkg::*, xc_cfg_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  wb_adr_t       wb_adr,
	input  wb_data_t      wb_dat_w,
	input  global_cfg_t   cfg_global,
	input  line_cfg_arr_t cfg_lines,
	output wb_data_t      wb_dat_r,
	output logic          wb_ack,
	output cmd_t          cmd
);

	// New request, seen while the previous ack is not pending.
	logic req;
	// Write to the command word.
	logic cmd_wr;
	// Readback word for the current address.
	wb_data_t rd_word;
	// Command byte and its strobe.
	logic cmd_valid;
	cmd_byte_t cmd_data;

	assign req = wb_cyc && wb_stb && !wb_ack;
	assign cmd_wr = req && wb_we && (wb_adr == wb_adr_t'(`XC_REG_CMD));

	// Ack and command strobe, both single cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			wb_ack <= req;
			cmd_valid <= cmd_wr;
		end
	end

	// Command byte, held until the next command write.
	always_ff @(posedge clk) begin
		if (cmd_wr) begin
			cmd_data <= wb_dat_w[7:0];
		end
	end

	assign cmd = '{valid: cmd_valid, data: cmd_data};

	// Readback decode.
	// Unmapped addresses read as zero.
	always_comb begin
		rd_word = '0;
		if (wb_adr == wb_adr_t'(`XC_REG_CMD)) begin
			rd_word[$bits(global_cfg_t)-1:0] = cfg_global;
		end
		for (int n = 0; n < `XC_NUM_LINES; n++) begin
			// Even word holds the taps.
			if (wb_adr == wb_adr_t'(`XC_REG_LINE_BASE + 2 * n)) begin
				rd_word[11:0] = cfg_lines[n].cross_idx;
				rd_word[23:12] = cfg_lines[n].auto_idx;
			end
			// Odd word holds bias, test and LED pattern.
			if (wb_adr == wb_adr_t'(`XC_REG_LINE_BASE + 2 * n + 1)) begin
				rd_word[7:0] = cfg_lines[n].bias;
				rd_word[11:8] = cfg_lines[n].test;
				rd_word[15:12] = cfg_lines[n].leds;
			end
		end
	end

	// Read data registered on the same edge as ack.
	always_ff @(posedge clk) begin
		if (req && !wb_we) begin
			wb_dat_r <= rd_word;
		end
	end

endmodule

/* design/cmd_parser.sv */
/*
  Command decoder and settings register file.
  A valid command updates the registers on the next edge. Per-line
  commands act on the current line and are dropped when it is
  XC_NUM_LINES or above. Unknown opcodes are ignored.
  All settings clear to zero on reset.
*/
`timescale 1ns/1ps
`include "xc_config.svh"

module cmd_parser
	import xc_cmd_pkg::*, xc_cfg_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  cmd_t          cmd,
	output global_cfg_t   cfg_global,
	output line_cfg_arr_t cfg_lines
);

	// Current line is a real line.
	logic line_ok;

	assign line_ok = cfg_global.current_line < line_sel_t'(`XC_NUM_LINES);

	// Global settings after command c.
	function automatic global_cfg_t apply_global(global_cfg_t g, cmd_byte_t c);
		global_cfg_t r;
		r = g;
		case (cmd_opcode(c))
			// Bits 7:6 pick which 2-bit slice of the line number.
			op_set_line: begin
				r.current_line[{c[7:6], 1'b0} +: 2] = c[5:4];
			end
			op_set_baud: begin
				r.baud_rate = c[7:4];
			end
			op_set_freq_div: begin
				r.clock_divider = c[7:4];
			end
			op_enable_capture: begin
				r.integrating = c[4];
				r.external_clock = c[5];
				r.fullwave = c[6];
			end
			default: begin
				// Per-line or unused opcode.
			end
		endcase
		return r;
	endfunction

	// Line settings after command c.
	function automatic line_cfg_t apply_line(line_cfg_t e, cmd_byte_t c);
		line_cfg_t r;
		tap_t tap;
		r = e;
		tap = c[6:4];
		if (cmd_is_delay(c)) begin
			// Bits 1:0 pick the tap, bit 7 picks auto over cross.
			if (c[7]) begin
				r.auto_idx[3 * c[1:0] +: 3] = tap;
			end else begin
				r.cross_idx[3 * c[1:0] +: 3] = tap;
			end
		end else begin
			case (cmd_opcode(c))
				// Only the taps, the rest of the line is kept.
				op_clear: begin
					r.cross_idx = '0;
					r.auto_idx = '0;
				end
				op_set_leds: begin
					r.leds = c[7:4];
				end
				// Bias is built two bits at a time.
				op_set_voltage: begin
					r.bias[{c[7:6], 1'b0} +: 2] = c[5:4];
				end
				op_enable_test: begin
					r.test = c[7:4];
				end
				default: begin
					// Global or unused opcode.
				end
			endcase
		end
		return r;
	endfunction

	// Global registers.
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_global <= '0;
		end else if (cmd.valid) begin
			cfg_global <= apply_global(cfg_global, cmd.data);
		end
	end

	// Line registers.
	// Only the entry that matches the current line is written.
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_lines <= '0;
		end else if (cmd.valid && line_ok) begin
			for (int n = 0; n < `XC_NUM_LINES; n++) begin
				if (cfg_global.current_line == line_sel_t'(n)) begin
					cfg_lines[n] <= apply_line(cfg_lines[n], cmd.data);
				end
			end
		end
	end

endmodule

/* design/bias_pwm.sv */
/*
  Bias PWM outputs, one per line.
  The prescaler ticks every clock_divider+1 clocks and each tick steps
  a shared 8-bit phase. An output is high while phase < bias, so bias 0
  is always low and bias 255 is high 255 steps out of 256.
  A new bias or divider takes effect at the next phase step.
*/
`timescale 1ns/1ps
`include "xc_config.svh"

module bias_pwm
	import xc_cfg_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  nibble_t                  clock_divider,
	input  bias_arr_t                line_bias,
	output logic [`XC_NUM_LINES-1:0] bias_out
);

	// Prescaler count.
	nibble_t prescale;
	// Phase step strobe.
	logic tick;
	// Shared phase and its value after the step.
	bias_t phase;
	bias_t phase_nxt;

	// Greater-or-equal recovers when the divider drops mid-count.
	assign tick = prescale >= clock_divider;
	// Wraps at 256.
	assign phase_nxt = phase + 1'b1;

	// Prescaler.
	always_ff @(posedge clk) begin
		if (rst) begin
			prescale <= '0;
		end else if (tick) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// Phase counter.
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (tick) begin
			phase <= phase_nxt;
		end
	end

	// Outputs follow the phase they are compared against.
	always_ff @(posedge clk) begin
		if (rst) begin
			bias_out <= '0;
		end else if (tick) begin
			for (int n = 0; n < `XC_NUM_LINES; n++) begin
				bias_out[n] <= phase_nxt < line_bias[n];
			end
		end
	end

endmodule

/* design/xc_ctrl_top.sv */
/*
  Control subsystem top level: bus slave, command parser, bias PWM.
  Settings reach the config outputs on the edge after the write ack.
  The line count is set in the config header, not by parameter.
*/
`timescale 1ns/1ps
`include "xc_config.svh"

module xc_ctrl_top
	import xc_cmd_pkg::*, xc_cfg_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  wb_adr_t                  wb_adr,
	input  wb_data_t                 wb_dat_w,
	output wb_data_t                 wb_dat_r,
	output logic                     wb_ack,
	output global_cfg_t              cfg_global,
	output line_cfg_arr_t            cfg_lines,
	output logic [`XC_NUM_LINES-1:0] bias_out
);

	// Command from the bus stage.
	cmd_t cmd;
	// Bias field of each line for the PWM.
	bias_arr_t line_bias;

	always_comb begin
		for (int n = 0; n < `XC_NUM_LINES; n++) begin
			line_bias[n] = cfg_lines[n].bias;
		end
	end

	cmd_wb_slave cmd_wb_slave_inst (
		.clk        (clk),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.cfg_global (cfg_global),
		.cfg_lines  (cfg_lines),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.cmd        (cmd)
	);

	cmd_parser cmd_parser_inst (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cfg_global (cfg_global),
		.cfg_lines  (cfg_lines)
	);

	bias_pwm bias_pwm_inst (
		.clk           (clk),
		.rst           (rst),
		.clock_divider (cfg_global.clock_divider),
		.line_bias     (line_bias),
		.bias_out      (bias_out)
	);

endmodule

/* bench/xc_ctrl_tb.sv */
/*
  Testbench for the correlator control subsystem.
  Drives Wishbone transfers on the falling edge and samples there too.
  A model of the settings follows every command sent and is compared
  with the config ports and with every readback word.
  The first mismatch stops the run; a watchdog bounds its length.
*/
`timescale 1ns/1ps
`include "xc_config.svh"

module xc_ctrl_tb
	import xc_cmd_pkg::*, xc_cfg_pkg::*;
;

	localparam int NL = `XC_NUM_LINES;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_TIMEOUT = 16;
	// Cycle budget of each part of the run.
	localparam int CHECK_CYCLES = 2 * (1 << `XC_WB_ADDR_W);
	localparam int XFER_CYCLES = 8;
	localparam int CMDS_PER_LINE = 12;
	localparam int LINE_ROUNDS = NL + 2;
	localparam int PROTO_XFERS = 24;
	localparam int TEST_CYCLES = RESET_CYCLES + CHECK_CYCLES
		+ LINE_ROUNDS * (4 + CMDS_PER_LINE) * (XFER_CYCLES + CHECK_CYCLES)
		+ 12 * (XFER_CYCLES + CHECK_CYCLES)
		+ 16 * (XFER_CYCLES + CHECK_CYCLES)
		+ PROTO_XFERS * XFER_CYCLES + CHECK_CYCLES
		+ (NL * 8 + 1) * XFER_CYCLES + CHECK_CYCLES + 2 * 256 * 16;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	global_cfg_t cfg_global;
	line_cfg_arr_t cfg_lines;
	logic [NL-1:0] bias_out;

	// Model of the settings.
	line_sel_t m_line;
	nibble_t m_baud;
	nibble_t m_div;
	logic m_integ;
	logic m_ext;
	logic m_full;
	delay_idx_t m_cross [NL];
	delay_idx_t m_auto [NL];
	bias_t m_bias [NL];
	nibble_t m_test [NL];
	nibble_t m_leds [NL];

	xc_ctrl_top xc_ctrl_top_inst (
		.clk        (clk),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.cfg_global (cfg_global),
		.cfg_lines  (cfg_lines),
		.bias_out   (bias_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(4 * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the tests did not finish in the expected time");
		$display("STATUS: FAIL");
		$fatal(1);
	end

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			$display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic model_reset();
		m_line = '0;
		m_baud = '0;
		m_div = '0;
		m_integ = 1'b0;
		m_ext = 1'b0;
		m_full = 1'b0;
		for (int n = 0; n < NL; n++) begin
			m_cross[n] = '0;
			m_auto[n] = '0;
			m_bias[n] = '0;
			m_test[n] = '0;
			m_leds[n] = '0;
		end
	endtask

	// Command rules, applied to the model.
	task automatic model_apply(input cmd_byte_t c);
		int ln;
		int sel;
		int tap;
		sel = int'(c[7:6]);
		tap = int'(c[1:0]);
		ln = int'(m_line);
		case (c[3:0])
			4'd1: m_line[2 * sel +: 2] = c[5:4];
			4'd3: m_baud = c[7:4];
			4'd8: m_div = c[7:4];
			4'd13: begin
				m_integ = c[4];
				m_ext = c[5];
				m_full = c[6];
			end
			default: begin
			end
		endcase
		// Per-line commands need a real current line.
		if (ln < NL) begin
			case (c[3:0])
				4'd0: begin
					m_cross[ln] = '0;
					m_auto[ln] = '0;
				end
				4'd2: m_leds[ln] = c[7:4];
				4'd4, 4'd5, 4'd6, 4'd7: begin
					if (c[7]) begin
						m_auto[ln][3 * tap +: 3] = c[6:4];
					end else begin
						m_cross[ln][3 * tap +: 3] = c[6:4];
					end
				end
				4'd9: m_bias[ln][2 * sel +: 2] = c[5:4];
				4'd12: m_test[ln] = c[7:4];
				default: begin
				end
			endcase
		end
	endtask

	// Register map word that the model predicts.
	function automatic wb_data_t expected_word(input int a);
		int n;
		wb_data_t w;
		w = '0;
		n = (a - 2) / 2;
		if (a == 0) begin
			w[18:0] = {m_line, m_baud, m_div, m_integ, m_ext, m_full};
		end else if (a >= 2 && n < NL) begin
			if (a % 2 == 0) begin
				w[23:0] = {m_auto[n], m_cross[n]};
			end else begin
				w[15:0] = {m_leds[n], m_test[n], m_bias[n]};
			end
		end
		return w;
	endfunction

	// One transfer, ack expected in the cycle after the request.
	task automatic bus_transfer(input logic we, input int a, input wb_data_t d,
			output wb_data_t rd);
		int cycles;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = wb_adr_t'(a);
		wb_dat_w = d;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!wb_ack && cycles < ACK_TIMEOUT);
		if (!wb_ack) begin
			$display("The DUT gave no ack within %0d cycles of a request", ACK_TIMEOUT);
			$display("STATUS: FAIL");
			$fatal(1);
		end
		check_value("ack latency", 64'(cycles), 64'd1);
		rd = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// Ack lasts one cycle only.
		@(negedge clk);
		check_value("wb_ack", 64'(wb_ack), 64'd0);
	endtask

	task automatic wb_read(input int a, output wb_data_t rd);
		bus_transfer(1'b0, a, $urandom(), rd);
	endtask

	// Command write with random upper data bits, then the model update.
	task automatic send_cmd(input cmd_byte_t c);
		wb_data_t d;
		wb_data_t rd;
		d = $urandom();
		d[7:0] = c;
		bus_transfer(1'b1, `XC_REG_CMD, d, rd);
		model_apply(c);
	endtask

	task automatic idle_cycles(input int k);
		repeat (k) begin
			@(negedge clk);
			check_value("wb_ack", 64'(wb_ack), 64'd0);
		end
	endtask

	// Line number sent in four 2-bit pieces.
	task automatic select_line(input line_sel_t l);
		for (int s = 3; s >= 0; s--) begin
			send_cmd({2'(s), l[2 * s +: 2], op_set_line});
		end
	endtask

	// Config ports and every word of the address space.
	task automatic check_all();
		wb_data_t rd;
		global_cfg_t exp_global;
		line_cfg_t exp_line;
		exp_global = '{current_line: m_line, baud_rate: m_baud, clock_divider: m_div,
			integrating: m_integ, external_clock: m_ext, fullwave: m_full};
		check_value("cfg_global", 64'(cfg_global), 64'(exp_global));
		for (int n = 0; n < NL; n++) begin
			exp_line = '{cross_idx: m_cross[n], auto_idx: m_auto[n], bias: m_bias[n],
				test: m_test[n], leds: m_leds[n]};
			check_value($sformatf("cfg_lines[%0d]", n), 64'(cfg_lines[n]), 64'(exp_line));
		end
		for (int a = 0; a < (1 << `XC_WB_ADDR_W); a++) begin
			wb_read(a, rd);
			check_value($sformatf("wb_dat_r at address %0d", a), 64'(rd),
				64'(expected_word(a)));
		end
	endtask

	// Random command from the setting opcodes.
	function automatic cmd_byte_t random_cmd();
		cmd_byte_t c;
		int pick;
		c = cmd_byte_t'($urandom());
		pick = $urandom_range(0, 9);
		case (pick)
			0, 1, 2: c[3:2] = 2'b01;
			3: c[3:0] = op_set_voltage;
			4: c[3:0] = op_enable_test;
			5: c[3:0] = op_set_leds;
			6: c[3:0] = op_set_baud;
			7: c[3:0] = op_set_freq_div;
			8: c[3:0] = op_enable_capture;
			default: c[3:0] = op_set_voltage;
		endcase
		return c;
	endfunction

	initial begin : stimulus
		int gap;
		int ln;
		int period;
		int counts [NL];
		line_sel_t l;
		cmd_byte_t c;
		wb_data_t rd;
		bias_t b;
		void'($urandom(32'h5d84_ece2));
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		model_reset();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Reset state.
		check_value("wb_ack", 64'(wb_ack), 64'd0);
		check_value("cfg_global", 64'(cfg_global), 64'd0);
		check_value("cfg_lines", 64'(cfg_lines[0]), 64'd0);
		check_value("bias_out", 64'(bias_out), 64'd0);
		check_all();

		// Every line, then two lines out of range.
		for (int r = 0; r < LINE_ROUNDS; r++) begin
			l = (r <= NL) ? line_sel_t'(r) : 8'hc4;
			select_line(l);
			check_all();
			for (int k = 0; k < CMDS_PER_LINE; k++) begin
				send_cmd(random_cmd());
				check_all();
			end
		end

		// CLEAR keeps bias, test and LED fields.
		// Cross and auto taps are both made nonzero first.
		ln = $urandom_range(0, NL - 1);
		select_line(line_sel_t'(ln));
		send_cmd(8'h55);
		send_cmd(8'hb6);
		send_cmd({4'ha, op_set_leds});
		send_cmd({4'h5, op_enable_test});
		send_cmd({4'h7, op_set_voltage});
		send_cmd({4'($urandom()), op_clear});
		check_value("cross_idx after CLEAR", 64'(cfg_lines[ln].cross_idx), 64'd0);
		check_value("auto_idx after CLEAR", 64'(cfg_lines[ln].auto_idx), 64'd0);
		check_value("bias after CLEAR", 64'(cfg_lines[ln].bias), 64'(m_bias[ln]));
		check_value("test after CLEAR", 64'(cfg_lines[ln].test), 64'(m_test[ln]));
		check_value("leds after CLEAR", 64'(cfg_lines[ln].leds), 64'(m_leds[ln]));
		check_all();

		// Unused opcodes and writes elsewhere change nothing.
		for (int k = 0; k < 8; k++) begin
			c = cmd_byte_t'($urandom());
			c[3:0] = (k % 4 == 0) ? 4'd10 : (k % 4 == 1) ? 4'd11 : (k % 4 == 2) ? 4'd14 : 4'd15;
			send_cmd(c);
			check_all();
			bus_transfer(1'b1, $urandom_range(1, (1 << `XC_WB_ADDR_W) - 1), $urandom(), rd);
			check_all();
		end

		// Back-to-back, then spaced transfers.
		for (int k = 0; k < PROTO_XFERS; k++) begin
			gap = (k < PROTO_XFERS / 2) ? 0 : $urandom_range(1, 5);
			if ($urandom_range(0, 1) == 1) begin
				ln = $urandom_range(0, (1 << `XC_WB_ADDR_W) - 1);
				wb_read(ln, rd);
				check_value($sformatf("wb_dat_r at address %0d", ln), 64'(rd),
					64'(expected_word(ln)));
			end else begin
				send_cmd(random_cmd());
			end
			idle_cycles(gap);
		end
		check_all();

		// PWM with a random divider; line 0 at full scale, line 1 off.
		send_cmd({4'($urandom()), op_set_freq_div});
		for (int n = 0; n < NL; n++) begin
			b = (n == 0) ? 8'hff : (n == 1) ? 8'h00 : bias_t'($urandom());
			select_line(line_sel_t'(n));
			for (int s = 0; s < 4; s++) begin
				send_cmd({2'(s), b[2 * s +: 2], op_set_voltage});
			end
		end
		check_all();
		period = 256 * (int'(m_div) + 1);
		repeat (period) @(negedge clk);
		for (int n = 0; n < NL; n++) begin
			counts[n] = 0;
		end
		repeat (period) begin
			@(negedge clk);
			for (int n = 0; n < NL; n++) begin
				if (bias_out[n]) begin
					counts[n]++;
				end
			end
		end
		for (int n = 0; n < NL; n++) begin
			check_value($sformatf("bias_out[%0d] high cycles", n), 64'(counts[n]),
				64'(int'(m_bias[n]) * (int'(m_div) + 1)));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+design
design/xc_cmd_pkg.sv
design/xc_cfg_pkg.sv
design/cmd_wb_slave.sv
design/cmd_parser.sv
design/bias_pwm.sv
design/xc_ctrl_top.sv
bench/xc_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the control subsystem testbench with Verilator and runs it.
# The run passes only if sim.log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	-f vlog.f \
	--top-module xc_ctrl_tb \
	-o xc_ctrl_sim

# The log is searched even when the simulation exits with an error.
./obj_dir/xc_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
else
	exit 1
fi
